// File: dv/core_stim.txt
// program words from 0x000, data words from @040, record count at @050
// records from @051: pc rd data next_pc, two records per line
@000
123450B7 67808113 00001197 40310233 FF000293 4022D313 002333B3 00232433
004144B3 00449513 00038463 00100593 00614463 00C0066F 00100593 00200593
014606E7 00100593 00200593 00202423 005006A3 00D00703 00D04783 00201803
00205883 00802903 0A000993 30599073 3002DAF3 30502A73 30046B73 00000073
00100073 00100593
@028
30043BF3 34102C73 34202CF3 30002D73 004C0D93 341D9073 00000013 30200073
@040
8001ABCD 00000000 DEADBEEF 11223344
@050
00000024
00000000 01 12345000 00000004  00000004 02 12345678 00000008
00000008 03 00001008 0000000C  0000000C 04 12344670 00000010
00000010 05 FFFFFFF0 00000014  00000014 06 FFFFFFFC 00000018
00000018 07 00000000 0000001C  0000001C 08 00000001 00000020
00000020 09 00001008 00000024  00000024 0A 00010080 00000028
00000028 00 00000000 00000030  00000030 00 00000000 00000034
00000034 0C 00000038 00000040  00000040 0D 00000044 0000004C
0000004C 00 00000000 00000050  00000050 00 00000000 00000054
00000054 0E FFFFFFF0 00000058  00000058 0F 000000F0 0000005C
0000005C 10 FFFF8001 00000060  00000060 11 00008001 00000064
00000064 12 12345678 00000068  00000068 13 000000A0 0000006C
0000006C 00 00000000 00000070  00000070 15 00000000 00000074
00000074 14 000000A0 00000078  00000078 16 00000005 0000007C
0000007C 00 00000000 000000A0  000000A0 17 0000000D 000000A4
000000A4 18 0000007C 000000A8  000000A8 19 0000000B 000000AC
000000AC 1A 0000000C 000000B0  000000B0 1B 00000080 000000B4
000000B4 00 00000000 000000B8  000000B8 00 00000000 000000BC
000000BC 00 00000000 00000080  00000080 00 00000000 00000084

// File: sources.f
+incdir+source
source/rv_isa_pkg.sv
source/pipe_ctrl_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/gpr_file.sv
source/csr_file.sv
source/execute_stage.sv
source/core_top.sv
dv/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sources.f --top-module core_tb -o core_tb_sim
out=$(./obj_dir/core_tb_sim)
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: dv/core_tb.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_tb;

  logic        clock;
  logic        reset;
  logic        retire_ready;
  logic [31:0] imem_addr, imem_data;
  logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_wen;
  logic [1:0]  dmem_size;
  logic        retire_valid, halt;
  logic [31:0] retire_pc, retire_data, retire_next_pc;
  logic [4:0]  retire_rd;

  // stim layout: program at 0x00, data words at 0x40, count at 0x50, records from 0x51
  logic [31:0] stim [256];
  logic [31:0] prog [64];
  logic [31:0] dinit [16];
  logic [7:0]  dbytes [64];
  logic [31:0] exp_pc [64];
  logic [4:0]  exp_rd [64];
  logic [31:0] exp_data [64];
  logic [31:0] exp_next [64];
  logic [5:0]  da1, da2, da3;
  logic [31:0] rng;
  logic        rec_bad;
  int          rec_count, rec_idx, tests_passed, tests_failed, errors;
  int          cycles, cycle_limit;

  core_top i_dut (
    .clock, .reset, .imem_addr, .imem_data,
    .dmem_addr, .dmem_wdata, .dmem_wen, .dmem_size, .dmem_rdata,
    .retire_valid, .retire_ready, .retire_pc, .retire_rd, .retire_data,
    .retire_next_pc, .halt
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      rec_bad = 1'b1;
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] expected,
                           input logic [4:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
      rec_bad = 1'b1;
    end
  endtask

  always #50 clock = ~clock;

  // instruction memory, word addressed
  assign imem_data = prog[imem_addr[7:2]];

  // little-endian byte memory, data returned from the addressed byte up
  assign da1 = dmem_addr[5:0] + 6'd1;
  assign da2 = dmem_addr[5:0] + 6'd2;
  assign da3 = dmem_addr[5:0] + 6'd3;
  assign dmem_rdata = {dbytes[da3], dbytes[da2], dbytes[da1], dbytes[dmem_addr[5:0]]};

  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 64; i++) begin
        dbytes[i] <= dinit[i / 4][8 * (i % 4) +: 8];
      end
    end else if (dmem_wen) begin
      dbytes[dmem_addr[5:0]] <= dmem_wdata[7:0];
      if (dmem_size != 2'b00) begin
        dbytes[da1] <= dmem_wdata[15:8];
      end
      if (dmem_size == 2'b10) begin
        dbytes[da2] <= dmem_wdata[23:16];
        dbytes[da3] <= dmem_wdata[31:24];
      end
    end
  end

  // random back-pressure on retire
  always @(posedge clock) begin
    #5;
    rng = lcg_next(rng);
    retire_ready = (rng[31:30] != 2'b00);
  end

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    if (!reset && retire_valid && retire_ready) begin
      if (rec_idx >= rec_count) begin
        $display("unexpected retire at pc %h after the last expected record", retire_pc);
        errors++;
      end else begin
        rec_bad = 1'b0;
        check_word($sformatf("rec%0d pc", rec_idx), exp_pc[rec_idx], retire_pc);
        check_reg($sformatf("rec%0d rd", rec_idx), exp_rd[rec_idx], retire_rd);
        check_word($sformatf("rec%0d data", rec_idx), exp_data[rec_idx], retire_data);
        check_word($sformatf("rec%0d next_pc", rec_idx), exp_next[rec_idx], retire_next_pc);
        if (rec_bad) begin
          tests_failed++;
          $display("rec%0d pc %h failed", rec_idx, exp_pc[rec_idx]);
        end else begin
          tests_passed++;
          $display("rec%0d pc %h ok", rec_idx, exp_pc[rec_idx]);
        end
        rec_idx++;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d records retired, halt %b",
               cycles, rec_idx, rec_count, halt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    retire_ready = 1'b0;
    rng          = 32'h682e9cae;
    rec_idx      = 0;
    tests_passed = 0;
    tests_failed = 0;
    errors       = 0;
    cycles       = 0;
    cycle_limit  = 0;
    for (int i = 0; i < 256; i++) begin
      stim[i] = 32'h0;
    end
    $readmemh("dv/core_stim.txt", stim);
    for (int i = 0; i < 64; i++) begin
      prog[i] = (i < 48 && stim[i] != 32'h0) ? stim[i] : `NOP_INST;
    end
    for (int i = 0; i < 16; i++) begin
      dinit[i] = stim[64 + i];
    end
    rec_count = int'(stim[80]);
    for (int i = 0; i < rec_count; i++) begin
      exp_pc[i]   = stim[81 + 4 * i];
      exp_rd[i]   = stim[82 + 4 * i][4:0];
      exp_data[i] = stim[83 + 4 * i];
      exp_next[i] = stim[84 + 4 * i];
    end
    cycle_limit = 20 * rec_count + 20;

    repeat (10) @(posedge clock);
    #5;
    reset = 1'b0;

    while (!(rec_idx == rec_count && halt)) begin
      @(posedge clock);
    end
    // nothing may retire once halted
    repeat (10) @(negedge clock);

    $display("records %0d, passed %0d, failed %0d, other errors %0d",
             rec_count, tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0 && rec_idx == rec_count) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: source/core_top.sv
`timescale 1ns/10ps

module core_top (
  input  logic        clock,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic        dmem_wen,
  output logic [1:0]  dmem_size,
  input  logic [31:0] dmem_rdata,
  output logic        retire_valid,
  input  logic        retire_ready,
  output logic [31:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data,
  output logic [31:0] retire_next_pc,
  output logic        halt
);

  pipe_ctrl_pkg::alu_funct_e alu_funct;
  pipe_ctrl_pkg::goto_e      goto;
  pipe_ctrl_pkg::csrw_e      csrw;
  logic        f_valid, d_in_ready, d_out_valid, e_in_ready, flush;
  logic        alu_src, alu_sw, rd_src;
  logic        gpr_wen, csr_wen, ecall_mark;
  logic [31:0] f_pc, f_inst, d_out_pc, redirect_pc;
  logic [31:0] val_a, val_b, val_c;
  logic [31:0] gpr_rdata1, gpr_rdata2, gpr_wdata, csr_rdata, csr_wdata;
  logic [4:0]  rd, exec_rd, gpr_raddr1, gpr_raddr2, gpr_waddr;
  logic [11:0] csr_raddr, csr_waddr;
  logic [3:0]  ls;

  fetch_stage i_fetch (
    .clock, .reset, .imem_addr, .imem_data,
    .out_valid(f_valid), .out_pc(f_pc), .out_inst(f_inst), .out_ready(d_in_ready),
    .flush, .redirect_pc, .halt
  );

  decode_stage i_decode (
    .clock, .reset, .gpr_raddr1, .gpr_rdata1, .gpr_raddr2, .gpr_rdata2,
    .csr_raddr, .csr_rdata, .flush, .exec_rd,
    .in_ready(d_in_ready), .in_valid(f_valid), .in_pc(f_pc), .in_inst(f_inst),
    .out_ready(e_in_ready), .out_valid(d_out_valid), .out_pc(d_out_pc), .out_inst(),
    .out_val_a(val_a), .out_val_b(val_b), .out_val_c(val_c), .out_alu_src(alu_src),
    .out_alu_funct(alu_funct), .out_alu_sw(alu_sw), .out_rd(rd), .out_rd_src(rd_src),
    .out_ls(ls), .out_goto(goto), .out_csrw(csrw)
  );

  gpr_file i_gpr (
    .clock, .reset, .raddr1(gpr_raddr1), .rdata1(gpr_rdata1), .raddr2(gpr_raddr2),
    .rdata2(gpr_rdata2), .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata)
  );

  csr_file i_csr (
    .clock, .reset, .raddr(csr_raddr), .rdata(csr_rdata), .wen(csr_wen),
    .waddr(csr_waddr), .wdata(csr_wdata), .ecall_mark
  );

  execute_stage i_execute (
    .clock, .reset, .in_valid(d_out_valid), .in_ready(e_in_ready), .in_pc(d_out_pc),
    .in_val_a(val_a), .in_val_b(val_b), .in_val_c(val_c), .in_alu_src(alu_src),
    .in_alu_funct(alu_funct), .in_alu_sw(alu_sw), .in_rd(rd), .in_rd_src(rd_src),
    .in_ls(ls), .in_goto(goto), .in_csrw(csrw), .exec_rd,
    .gpr_wen, .gpr_waddr, .gpr_wdata, .csr_wen, .csr_waddr, .csr_wdata, .ecall_mark,
    .dmem_addr, .dmem_wdata, .dmem_wen, .dmem_size, .dmem_rdata,
    .flush, .redirect_pc, .halt, .retire_valid, .retire_ready,
    .retire_pc, .retire_rd, .retire_data, .retire_next_pc
  );

endmodule

// File: source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [31:0]               in_pc,
  input  logic [31:0]               in_val_a,
  input  logic [31:0]               in_val_b,
  input  logic [31:0]               in_val_c,
  input  logic                      in_alu_src,
  input  pipe_ctrl_pkg::alu_funct_e in_alu_funct,
  input  logic                      in_alu_sw,
  input  logic [4:0]                in_rd,
  input  logic                      in_rd_src,
  input  logic [3:0]                in_ls,
  input  pipe_ctrl_pkg::goto_e      in_goto,
  input  pipe_ctrl_pkg::csrw_e      in_csrw,
  output logic [4:0]                exec_rd,
  output logic                      gpr_wen,
  output logic [4:0]                gpr_waddr,
  output logic [31:0]               gpr_wdata,
  output logic                      csr_wen,
  output logic [11:0]               csr_waddr,
  output logic [31:0]               csr_wdata,
  output logic                      ecall_mark,
  output logic [31:0]               dmem_addr,
  output logic [31:0]               dmem_wdata,
  output logic                      dmem_wen,
  output logic [1:0]                dmem_size,
  input  logic [31:0]               dmem_rdata,
  output logic                      flush,
  output logic [31:0]               redirect_pc,
  output logic                      halt,
  output logic                      retire_valid,
  input  logic                      retire_ready,
  output logic [31:0]               retire_pc,
  output logic [4:0]                retire_rd,
  output logic [31:0]               retire_data,
  output logic [31:0]               retire_next_pc
);

  pipe_ctrl_pkg::alu_funct_e alu_funct;
  pipe_ctrl_pkg::goto_e      goto;
  pipe_ctrl_pkg::csrw_e      csrw;
  logic        valid, alu_src, alu_sw, rd_src, fire, taken;
  logic [31:0] pc, val_a, val_b, val_c;
  logic [31:0] alu_a, alu_res, load_val, rd_val, target;
  logic [4:0]  rd;
  logic [3:0]  ls;

  assign fire = valid & retire_ready;
  // an ebreak in hand blocks further intake
  assign in_ready = ~halt & (~valid | (retire_ready & (csrw != pipe_ctrl_pkg::CSRW_EBREAK)));
  assign exec_rd = valid ? rd : 5'h0;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
      halt  <= 1'b0;
    end else begin
      if (in_valid & in_ready) begin
        valid <= 1'b1;
      end else if (fire) begin
        valid <= 1'b0;
      end
      if (fire && (csrw == pipe_ctrl_pkg::CSRW_EBREAK)) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid & in_ready) begin
      pc        <= in_pc;
      val_a     <= in_val_a;
      val_b     <= in_val_b;
      val_c     <= in_val_c;
      alu_src   <= in_alu_src;
      alu_funct <= in_alu_funct;
      alu_sw    <= in_alu_sw;
      rd        <= in_rd;
      rd_src    <= in_rd_src;
      ls        <= in_ls;
      goto      <= in_goto;
      csrw      <= in_csrw;
    end
  end

  assign alu_a = alu_src ? pc : val_a;

  always_comb begin
    case (alu_funct)
      pipe_ctrl_pkg::ALU_ADD: alu_res = alu_sw ? alu_a - val_b : alu_a + val_b;
      pipe_ctrl_pkg::ALU_SHL: alu_res = alu_a << val_b[4:0];
      pipe_ctrl_pkg::ALU_LTS: alu_res = {31'h0, $signed(alu_a) < $signed(val_b)};
      pipe_ctrl_pkg::ALU_LTU: alu_res = {31'h0, alu_a < val_b};
      pipe_ctrl_pkg::ALU_XOR: alu_res = alu_a ^ val_b;
      pipe_ctrl_pkg::ALU_SHR: begin
        // arithmetic shift keeps the sign bit
        if (alu_sw) begin
          alu_res = $signed(alu_a) >>> val_b[4:0];
        end else begin
          alu_res = alu_a >> val_b[4:0];
        end
      end
      pipe_ctrl_pkg::ALU_OR:  alu_res = alu_a | val_b;
      // switched AND clears bits for csrrc
      default: alu_res = alu_sw ? alu_a & ~val_b : alu_a & val_b;
    endcase
  end

  // ls[2] selects sign extension on loads
  always_comb begin
    case (ls[1:0])
      2'b00:   load_val = {{24{ls[2] & dmem_rdata[7]}}, dmem_rdata[7:0]};
      2'b01:   load_val = {{16{ls[2] & dmem_rdata[15]}}, dmem_rdata[15:0]};
      default: load_val = dmem_rdata;
    endcase
    case (goto)
      pipe_ctrl_pkg::GOTO_NONE:       taken = 1'b0;
      pipe_ctrl_pkg::GOTO_BR_NONZERO: taken = |alu_res;
      pipe_ctrl_pkg::GOTO_BR_ZERO:    taken = ~|alu_res;
      default:                        taken = 1'b1;
    endcase
    case (goto)
      pipe_ctrl_pkg::GOTO_REG_REL: target = (val_a + val_c) & ~32'h1;
      pipe_ctrl_pkg::GOTO_ABS_A:   target = val_a;
      default:                     target = pc + val_c;
    endcase
  end

  assign rd_val = ls[3] ? load_val : (rd_src ? val_a : alu_res);

  assign gpr_wen   = fire & (rd != 5'h0);
  assign gpr_waddr = rd;
  assign gpr_wdata = rd_val;

  assign csr_wen    = fire & ((csrw == pipe_ctrl_pkg::CSRW_ALU) |
                              (csrw == pipe_ctrl_pkg::CSRW_VAL_B));
  assign csr_waddr  = val_c[11:0];
  assign csr_wdata  = (csrw == pipe_ctrl_pkg::CSRW_ALU) ? alu_res : val_b;
  // ecall is the only jump that writes a CSR
  assign ecall_mark = fire & (csrw == pipe_ctrl_pkg::CSRW_VAL_B) &
                      (goto == pipe_ctrl_pkg::GOTO_ABS_A);

  assign dmem_addr  = alu_res;
  assign dmem_wdata = val_c;
  assign dmem_size  = ls[1:0];
  assign dmem_wen   = fire & ~ls[3] & ls[2];

  assign flush       = fire & taken;
  assign redirect_pc = target;

  assign retire_valid   = valid;
  assign retire_pc      = pc;
  assign retire_rd      = rd;
  assign retire_data    = (rd == 5'h0) ? 32'h0 : rd_val;
  assign retire_next_pc = taken ? target : pc + 32'd4;

  assert property (@(posedge clock) disable iff (reset)
    retire_valid & ~retire_ready |=> retire_valid & $stable(retire_pc) &
      $stable(retire_rd) & $stable(retire_data) & $stable(retire_next_pc));

endmodule

// File: source/csr_file.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module csr_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [11:0] raddr,
  output logic [31:0] rdata,
  input  logic        wen,
  input  logic [11:0] waddr,
  input  logic [31:0] wdata,
  input  logic        ecall_mark
);

  logic [31:0] mstatus, mtvec, mepc, mcause;

  always_comb begin
    case (raddr)
      `CSR_MSTATUS: rdata = mstatus;
      `CSR_MTVEC:   rdata = mtvec;
      `CSR_MEPC:    rdata = mepc;
      `CSR_MCAUSE:  rdata = mcause;
      default:      rdata = 32'h0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= 32'h0;
      mtvec   <= 32'h0;
      mepc    <= 32'h0;
      mcause  <= 32'h0;
    end else begin
      if (wen) begin
        case (waddr)
          `CSR_MSTATUS: mstatus <= wdata;
          `CSR_MTVEC:   mtvec <= wdata;
          `CSR_MEPC:    mepc <= wdata;
          `CSR_MCAUSE:  mcause <= wdata;
          default: ;
        endcase
      end
      // cause lands together with the mepc write of ecall
      if (ecall_mark) begin
        mcause <= `MCAUSE_ECALL;
      end
    end
  end

endmodule

// File: source/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata2,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (wen && (waddr != 5'h0)) begin
      // x0 is never written, so it keeps its reset zero
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module decode_stage (
  input  logic                      clock,
  input  logic                      reset,
  output logic [4:0]                gpr_raddr1,
  input  logic [31:0]               gpr_rdata1,
  output logic [4:0]                gpr_raddr2,
  input  logic [31:0]               gpr_rdata2,
  output logic [11:0]               csr_raddr,
  input  logic [31:0]               csr_rdata,
  input  logic                      flush,
  input  logic [4:0]                exec_rd,
  output logic                      in_ready,
  input  logic                      in_valid,
  input  logic [31:0]               in_pc,
  input  logic [31:0]               in_inst,
  input  logic                      out_ready,
  output logic                      out_valid,
  output logic [31:0]               out_pc,
  output logic [31:0]               out_inst,
  output logic [31:0]               out_val_a,
  output logic [31:0]               out_val_b,
  output logic [31:0]               out_val_c,
  output logic                      out_alu_src,
  output pipe_ctrl_pkg::alu_funct_e out_alu_funct,
  output logic                      out_alu_sw,
  output logic [4:0]                out_rd,
  output logic                      out_rd_src,
  output logic [3:0]                out_ls,
  output pipe_ctrl_pkg::goto_e      out_goto,
  output pipe_ctrl_pkg::csrw_e      out_csrw
);

  pipe_ctrl_pkg::hold_state_e state;
  rv_isa_pkg::opcode_e        opcode;
  pipe_ctrl_pkg::alu_funct_e  sys_funct;
  pipe_ctrl_pkg::alu_funct_e  br_funct;
  pipe_ctrl_pkg::goto_e       br_goto;
  logic [2:0]  funct3;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_z;
  logic [4:0]  rs1, rs2;
  logic        need_rs1, need_rs2, gpr_raw;
  logic        zicsr, ebreak;

  assign in_ready = (state == pipe_ctrl_pkg::ST_IDLE) | (out_valid & out_ready) | flush;
  assign out_valid = (state == pipe_ctrl_pkg::ST_HOLD) & ~flush & ~gpr_raw;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= pipe_ctrl_pkg::ST_IDLE;
      out_pc   <= `RESET_PC;
      out_inst <= `NOP_INST;
    end else if (in_ready & in_valid) begin
      state    <= pipe_ctrl_pkg::ST_HOLD;
      out_pc   <= in_pc;
      out_inst <= in_inst;
    end else if (in_ready) begin
      state <= pipe_ctrl_pkg::ST_IDLE;
    end
  end

  assign opcode = rv_isa_pkg::opcode_e'(out_inst[6:2]);
  assign funct3 = out_inst[14:12];
  assign rs1    = out_inst[19:15];
  assign rs2    = out_inst[24:20];

  assign imm_i = {{20{out_inst[31]}}, out_inst[31:20]};
  assign imm_s = {{20{out_inst[31]}}, out_inst[31:25], out_inst[11:7]};
  assign imm_b = {{20{out_inst[31]}}, out_inst[7], out_inst[30:25], out_inst[11:8], 1'b0};
  assign imm_u = {out_inst[31:12], 12'h0};
  assign imm_j = {{12{out_inst[31]}}, out_inst[19:12], out_inst[20], out_inst[30:21], 1'b0};
  assign imm_z = {27'h0, rs1};

  assign gpr_raddr1 = rs1;
  assign gpr_raddr2 = rs2;

  // only Zicsr has a nonzero funct3 among system instructions
  assign zicsr  = |funct3;
  assign ebreak = out_inst[21:20] == 2'b01;
  // ecall reads mtvec, mret reads mepc
  assign csr_raddr = zicsr ? out_inst[31:20] : (out_inst[21] ? `CSR_MEPC : `CSR_MTVEC);

  always_comb begin
    case (opcode)
      rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_BRANCH, rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_RI, rv_isa_pkg::OP_RR: need_rs1 = 1'b1;
      rv_isa_pkg::OP_SYS: need_rs1 = zicsr & ~funct3[2];
      default: need_rs1 = 1'b0;
    endcase
    need_rs2 = (opcode == rv_isa_pkg::OP_BRANCH) | (opcode == rv_isa_pkg::OP_STORE) |
               (opcode == rv_isa_pkg::OP_RR);
  end

  // stall while execute still owes a needed source
  assign gpr_raw = (need_rs1 & (|rs1) & (rs1 == exec_rd)) |
                   (need_rs2 & (|rs2) & (rs2 == exec_rd));

  always_comb begin
    case (rv_isa_pkg::csr_f3_e'(funct3))
      rv_isa_pkg::CSRF_RS, rv_isa_pkg::CSRF_RSI: sys_funct = pipe_ctrl_pkg::ALU_OR;
      rv_isa_pkg::CSRF_RC, rv_isa_pkg::CSRF_RCI: sys_funct = pipe_ctrl_pkg::ALU_AND;
      default: sys_funct = pipe_ctrl_pkg::ALU_ADD;
    endcase
    // branch compares, then a zero test of the result
    case (rv_isa_pkg::branch_f3_e'(funct3))
      rv_isa_pkg::BR_BLT, rv_isa_pkg::BR_BGE: br_funct = pipe_ctrl_pkg::ALU_LTS;
      rv_isa_pkg::BR_BLTU, rv_isa_pkg::BR_BGEU: br_funct = pipe_ctrl_pkg::ALU_LTU;
      default: br_funct = pipe_ctrl_pkg::ALU_XOR;
    endcase
    case (rv_isa_pkg::branch_f3_e'(funct3))
      rv_isa_pkg::BR_BEQ, rv_isa_pkg::BR_BGE, rv_isa_pkg::BR_BGEU:
        br_goto = pipe_ctrl_pkg::GOTO_BR_ZERO;
      default: br_goto = pipe_ctrl_pkg::GOTO_BR_NONZERO;
    endcase
  end

  always_comb begin
    out_val_a     = 32'h0;
    out_val_b     = 32'h0;
    out_val_c     = 32'h0;
    out_alu_src   = 1'b0;
    out_alu_funct = pipe_ctrl_pkg::ALU_ADD;
    out_alu_sw    = 1'b0;
    out_rd        = out_inst[11:7];
    out_rd_src    = 1'b0;
    out_ls        = 4'h0;
    out_goto      = pipe_ctrl_pkg::GOTO_NONE;
    out_csrw      = pipe_ctrl_pkg::CSRW_NONE;
    case (opcode)
      rv_isa_pkg::OP_LUI: out_val_b = imm_u;
      rv_isa_pkg::OP_AUIPC: begin
        out_val_b   = imm_u;
        out_alu_src = 1'b1;
      end
      // link value is pc + 4
      rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
        out_val_a   = gpr_rdata1;
        out_val_b   = 32'h4;
        out_val_c   = (opcode == rv_isa_pkg::OP_JAL) ? imm_j : imm_i;
        out_alu_src = 1'b1;
        out_goto    = (opcode == rv_isa_pkg::OP_JAL) ? pipe_ctrl_pkg::GOTO_PC_REL :
                                                       pipe_ctrl_pkg::GOTO_REG_REL;
      end
      rv_isa_pkg::OP_BRANCH: begin
        out_val_a     = gpr_rdata1;
        out_val_b     = gpr_rdata2;
        out_val_c     = imm_b;
        out_alu_funct = br_funct;
        out_rd        = 5'h0;
        out_goto      = br_goto;
      end
      rv_isa_pkg::OP_LOAD: begin
        out_val_a = gpr_rdata1;
        out_val_b = imm_i;
        out_ls    = {1'b1, ~funct3[2], funct3[1:0]};
      end
      rv_isa_pkg::OP_STORE: begin
        out_val_a = gpr_rdata1;
        out_val_b = imm_s;
        out_val_c = gpr_rdata2;
        out_rd    = 5'h0;
        out_ls    = {2'b01, funct3[1:0]};
      end
      rv_isa_pkg::OP_RI, rv_isa_pkg::OP_RR: begin
        out_val_a     = gpr_rdata1;
        out_val_b     = (opcode == rv_isa_pkg::OP_RR) ? gpr_rdata2 : imm_i;
        out_alu_funct = pipe_ctrl_pkg::alu_funct_e'(funct3);
        out_alu_sw    = out_inst[30] & ((opcode == rv_isa_pkg::OP_RR) |
                        (funct3 == pipe_ctrl_pkg::ALU_SHR));
      end
      // ecall writes pc into mepc, Zicsr writes the named CSR
      rv_isa_pkg::OP_SYS: begin
        out_val_a     = csr_rdata;
        out_val_b     = zicsr ? (funct3[2] ? imm_z : gpr_rdata1) : out_pc;
        out_val_c     = {20'h0, zicsr ? out_inst[31:20] : `CSR_MEPC};
        out_alu_funct = sys_funct;
        out_alu_sw    = &funct3[1:0];
        out_rd_src    = 1'b1;
        out_goto      = (zicsr | ebreak) ? pipe_ctrl_pkg::GOTO_NONE : pipe_ctrl_pkg::GOTO_ABS_A;
        if (zicsr) begin
          out_csrw = (funct3[1:0] == 2'b01) ? pipe_ctrl_pkg::CSRW_VAL_B : pipe_ctrl_pkg::CSRW_ALU;
        end else if (ebreak) begin
          out_csrw = pipe_ctrl_pkg::CSRW_EBREAK;
        end else if (!out_inst[21]) begin
          out_csrw = pipe_ctrl_pkg::CSRW_VAL_B;
        end
      end
      default: ;
    endcase
  end

  // an offered item waits unchanged until it moves, unless a flush squashes it
  assert property (@(posedge clock) disable iff (reset)
    out_valid & ~out_ready |=> flush | (out_valid & $stable(out_pc) & $stable(out_inst)));

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module fetch_stage (
  input  logic        clock,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic        out_valid,
  output logic [31:0] out_pc,
  output logic [31:0] out_inst,
  input  logic        out_ready,
  input  logic        flush,
  input  logic [31:0] redirect_pc,
  input  logic        halt
);

  pipe_ctrl_pkg::hold_state_e state;
  logic [31:0] pc;
  logic        load;

  assign imem_addr = pc;
  assign out_valid = (state == pipe_ctrl_pkg::ST_HOLD) & ~flush;
  // buffer is free when empty or when its word leaves this cycle
  assign load = ~halt & ((state == pipe_ctrl_pkg::ST_IDLE) | out_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= pipe_ctrl_pkg::ST_IDLE;
      pc       <= `RESET_PC;
      out_pc   <= `RESET_PC;
      out_inst <= `NOP_INST;
    end else if (flush) begin
      state <= pipe_ctrl_pkg::ST_IDLE;
      pc    <= redirect_pc;
    end else if (load) begin
      state    <= pipe_ctrl_pkg::ST_HOLD;
      pc       <= pc + 32'd4;
      out_pc   <= pc;
      out_inst <= imem_data;
    end else if (out_valid & out_ready) begin
      state <= pipe_ctrl_pkg::ST_IDLE;
    end
  end

endmodule

// File: source/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

  // same encoding as funct3 of the ALU instructions
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SHL = 3'b001,
    ALU_LTS = 3'b010,
    ALU_LTU = 3'b011,
    ALU_XOR = 3'b100,
    ALU_SHR = 3'b101,
    ALU_OR  = 3'b110,
    ALU_AND = 3'b111
  } alu_funct_e;

  // jump target kind
  typedef enum logic [2:0] {
    GOTO_NONE       = 3'b000,
    GOTO_PC_REL     = 3'b001,
    GOTO_REG_REL    = 3'b010,
    GOTO_ABS_A      = 3'b011,
    GOTO_BR_NONZERO = 3'b100,
    GOTO_BR_ZERO    = 3'b101
  } goto_e;

  // where the CSR write value comes from
  typedef enum logic [1:0] {
    CSRW_NONE   = 2'b00,
    CSRW_ALU    = 2'b01,
    CSRW_VAL_B  = 2'b10,
    CSRW_EBREAK = 2'b11
  } csrw_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_HOLD = 1'b1
  } hold_state_e;

endpackage

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_RI     = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_RR     = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100
  } opcode_e;

  // branch funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_f3_e;

  // Zicsr funct3, bit 2 picks the zimm forms
  typedef enum logic [2:0] {
    CSRF_RW  = 3'b001,
    CSRF_RS  = 3'b010,
    CSRF_RC  = 3'b011,
    CSRF_RWI = 3'b101,
    CSRF_RSI = 3'b110,
    CSRF_RCI = 3'b111
  } csr_f3_e;

endpackage

// File: source/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from M-mode
`define MCAUSE_ECALL 32'd11

`endif
